// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert --timing --timescale 1ns/1ps -j 0
TOP       = tb_ramio
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

# the log decides, not the exit status of the pipe
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
+incdir+hdl
hdl/ramio_pkg.sv
hdl/ramio_decode.sv
hdl/ramio_cache.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/ramio_top.sv
verif/ramio_checker.sv
verif/tb_ramio.sv

// ==== hdl/ramio_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ramio_settings.svh"

module ramio_cache (
  input  wire                  clk,
  input  wire                  arst_n,
  input  wire                  start,
  input  wire ramio_pkg::ram_req_t req,
  output logic                 done,
  output logic [31:0]          rd_word,
  output ramio_pkg::br_cmd_t   br_cmd,
  output logic                 br_cmd_en,
  input  wire [63:0]           br_rd_data,
  input  wire                  br_rd_data_valid
);

  localparam int unsigned INDEX_W = `CACHE_LINE_INDEX_BITWIDTH;
  localparam int unsigned TAG_W   = `RAM_ADDRESS_BITWIDTH - `CACHE_LINE_INDEX_BITWIDTH;
  localparam int unsigned LINES   = 1 << INDEX_W;

  typedef enum logic [1:0] {
    st_idle,
    st_fetch,  // wait out a write-back, then issue the read
    st_wait    // read outstanding
  } state_e;

  state_e state;

  // line storage
  logic [TAG_W-1:0] tag_mem  [LINES];
  logic [63:0]      line_mem [LINES];
  logic [LINES-1:0] valid;
  logic [LINES-1:0] dirty;

  logic [INDEX_W-1:0] index;
  logic [TAG_W-1:0]   tag;
  logic [63:0]        line;
  logic               hit;
  logic               go;
  logic               retry;  // replay lookup after refill
  logic               victim_dirty;
  logic               store;
  logic               refill;

  logic [31:0]        word;
  logic [7:0]         bsel;
  logic [15:0]        hsel;
  logic [31:0]        rd_next;
  logic [63:0]        merged;

  assign index = req.address[3 +: INDEX_W];
  assign tag   = req.address[3 + INDEX_W +: TAG_W];
  assign line  = line_mem[index];
  assign hit   = valid[index] && (tag_mem[index] == tag);
  assign go    = start || retry;

  assign victim_dirty = valid[index] && dirty[index];
  assign store  = (state == st_idle) && go && hit && (req.write_type != ramio_pkg::wr_none);
  assign refill = (state == st_wait) && br_rd_data_valid;

  // ------------------------------------------------------------------------
  // load lane select and extension
  // ------------------------------------------------------------------------
  assign word = line[{req.address[2], 5'b0} +: 32];
  assign bsel = word[{req.address[1:0], 3'b0} +: 8];
  assign hsel = word[{req.address[1], 4'b0} +: 16];

  always_comb begin
    case (req.read_type)
      ramio_pkg::rd_byte:   rd_next = {{24{bsel[7]}}, bsel};
      ramio_pkg::rd_half:   rd_next = {{16{hsel[15]}}, hsel};
      ramio_pkg::rd_byte_u: rd_next = {24'b0, bsel};
      ramio_pkg::rd_half_u: rd_next = {16'b0, hsel};
      default:              rd_next = word;
    endcase
  end

  // store merge into the 8-byte line
  always_comb begin
    merged = line;
    case (req.write_type)
      ramio_pkg::wr_byte: merged[{req.address[2:0], 3'b0} +: 8] = req.data_in[7:0];
      ramio_pkg::wr_half: merged[{req.address[2:1], 4'b0} +: 16] = req.data_in[15:0];
      ramio_pkg::wr_word: merged[{req.address[2], 5'b0} +: 32] = req.data_in;
      default: ;
    endcase
  end

  // ------------------------------------------------------------------------
  // control fsm
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= st_idle;
      valid     <= '0;
      dirty     <= '0;
      done      <= 1'b0;
      br_cmd_en <= 1'b0;
      retry     <= 1'b0;
    end else begin
      done      <= 1'b0;
      br_cmd_en <= 1'b0;
      retry     <= 1'b0;
      case (state)
        st_idle: begin
          if (go && hit) begin
            done <= 1'b1;
            if (store) begin
              dirty[index] <= 1'b1;
            end
          end else if (go) begin
            br_cmd_en <= victim_dirty;  // write-back first
            state     <= st_fetch;
          end
        end
        st_fetch: begin
          if (!br_cmd_en) begin  // write-back finished or none issued
            br_cmd_en <= 1'b1;
            state     <= st_wait;
          end
        end
        st_wait: begin
          if (br_rd_data_valid) begin
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;
            retry        <= 1'b1;
            state        <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (refill) begin
      line_mem[index] <= br_rd_data;
      tag_mem[index]  <= tag;
    end else if (store) begin
      line_mem[index] <= merged;
    end
  end

  // load result and burst command word
  always_ff @(posedge clk) begin
    if ((state == st_idle) && go && hit) begin
      rd_word <= rd_next;
    end
    if ((state == st_idle) && go && !hit) begin
      br_cmd <= '{cmd: ramio_pkg::br_write, addr: {tag_mem[index], index}, wr_data: line};
    end else if ((state == st_fetch) && !br_cmd_en) begin
      br_cmd <= '{cmd: ramio_pkg::br_read, addr: {tag, index}, wr_data: line};
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ramio_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ramio_settings.svh"

module ramio_decode (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire                         enable,
  input  wire ramio_pkg::write_type_e write_type,
  input  wire ramio_pkg::read_type_e  read_type,
  input  wire [31:0]                  address,
  input  wire [31:0]                  data_in,
  input  wire                         done,
  output logic                        busy,
  output ramio_pkg::ram_req_t         req,
  output ramio_pkg::target_e          target,
  output logic                        cache_start,
  output logic                        tx_start,
  output logic                        led_write,
  output logic                        io_read
);

  logic               accept;
  logic               is_write;
  logic               to_cache;
  logic               to_tx;
  logic               to_led;
  ramio_pkg::target_e addr_target;

  assign accept = enable && !busy;  // requests during busy are dropped
  assign is_write = (write_type != ramio_pkg::wr_none);

  // address map lookup
  always_comb begin
    if (address == `ADDR_LED) begin
      addr_target = ramio_pkg::tgt_led;
    end else if (address == `ADDR_UART_OUT) begin
      addr_target = ramio_pkg::tgt_uart_out;
    end else if (address == `ADDR_UART_IN) begin
      addr_target = ramio_pkg::tgt_uart_in;
    end else begin
      addr_target = ramio_pkg::tgt_ram;
    end
  end

  assign to_cache = (addr_target == ramio_pkg::tgt_ram);
  assign to_tx    = (addr_target == ramio_pkg::tgt_uart_out) && is_write;
  assign to_led   = (addr_target == ramio_pkg::tgt_led) && is_write;

  // busy and the start strobes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy        <= 1'b0;
      cache_start <= 1'b0;
      tx_start    <= 1'b0;
      led_write   <= 1'b0;
      io_read     <= 1'b0;
    end else begin
      cache_start <= accept && to_cache;
      tx_start    <= accept && to_tx;
      led_write   <= accept && to_led;
      io_read     <= accept && !to_cache && !to_tx && !to_led;  // any other i/o access
      if (accept) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
    end
  end

  // request is held stable for the blocks until done
  always_ff @(posedge clk) begin
    if (accept) begin
      req <= '{write_type: write_type, read_type: read_type,
               address: address, data_in: data_in};
      target <= addr_target;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ramio_pkg.sv ====
`default_nettype none

`include "ramio_settings.svh"

package ramio_pkg;

  // store size from the core
  typedef enum logic [1:0] {
    wr_none,
    wr_byte,
    wr_half,
    wr_word
  } write_type_e;

  // load size, _u variants zero extend
  typedef enum logic [2:0] {
    rd_none,
    rd_byte,
    rd_half,
    rd_word,
    rd_byte_u,
    rd_half_u
  } read_type_e;

  typedef enum logic [1:0] {
    tgt_ram,
    tgt_uart_out,
    tgt_uart_in,
    tgt_led
  } target_e;

  typedef struct packed {
    write_type_e write_type;
    read_type_e  read_type;
    logic [31:0] address;  // byte address
    logic [31:0] data_in;
  } ram_req_t;

  typedef enum logic {
    br_read  = 1'b0,
    br_write = 1'b1
  } br_op_e;

  // one command word toward the burst controller
  typedef struct packed {
    br_op_e                             cmd;
    logic [`RAM_ADDRESS_BITWIDTH-1:0]   addr;     // 64-bit word address
    logic [63:0]                        wr_data;
  } br_cmd_t;

endpackage

`default_nettype wire

// ==== hdl/ramio_settings.svh ====
`ifndef RAMIO_SETTINGS_SVH
`define RAMIO_SETTINGS_SVH

// ------------------------------------------------------------------------
// burst ram and cache geometry
// ------------------------------------------------------------------------
// br_addr counts 64-bit words
`define RAM_ADDRESS_BITWIDTH 21
// 16 lines of 8 bytes
`define CACHE_LINE_INDEX_BITWIDTH 4

// ------------------------------------------------------------------------
// clock and serial line
// ------------------------------------------------------------------------
`define CLOCK_FREQUENCY_HZ 30_000_000
`define UART_BAUD_RATE 115200

// ------------------------------------------------------------------------
// i/o address map, everything below goes to ram
// ------------------------------------------------------------------------
`define ADDR_LED 32'hFFFF_FFFC
`define ADDR_UART_OUT 32'hFFFF_FFF8
`define ADDR_UART_IN 32'hFFFF_FFF4

`endif

// ==== hdl/ramio_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ramio_settings.svh"

module ramio_top (
  input  wire                             clk,
  input  wire                             arst_n,
  input  wire                             enable,
  input  wire ramio_pkg::write_type_e     write_type,
  input  wire ramio_pkg::read_type_e      read_type,
  input  wire [31:0]                      address,
  input  wire [31:0]                      data_in,
  output logic [31:0]                     data_out,
  output logic                            data_out_ready,
  output logic                            busy,
  output logic [3:0]                      led,
  output logic                            uart_tx,
  input  wire                             uart_rx,
  output logic                            br_cmd,     // 0 read, 1 write
  output logic                            br_cmd_en,
  output logic [`RAM_ADDRESS_BITWIDTH-1:0] br_addr,   // 64-bit word address
  output logic [63:0]                     br_wr_data,
  input  wire [63:0]                      br_rd_data,
  input  wire                             br_rd_data_valid
);

  ramio_pkg::ram_req_t req;
  ramio_pkg::target_e  target;
  ramio_pkg::br_cmd_t  br_command;
  logic                cache_start;
  logic                tx_start;
  logic                led_write;
  logic                io_read;
  logic                cache_done;
  logic                io_done;
  logic                tx_busy;
  logic                tx_busy_q;
  logic                done;
  logic                take;
  logic [31:0]         cache_word;
  logic [31:0]         io_word;
  logic [8:0]          rx_byte;

  ramio_decode decode (
    .clk, .arst_n, .enable, .write_type, .read_type, .address, .data_in,
    .done, .busy, .req, .target, .cache_start, .tx_start, .led_write, .io_read
  );

  ramio_cache cache (
    .clk, .arst_n, .start(cache_start), .req, .done(cache_done), .rd_word(cache_word),
    .br_cmd(br_command), .br_cmd_en, .br_rd_data, .br_rd_data_valid
  );

  uart_tx transmitter (
    .clk, .arst_n, .start(tx_start), .data(req.data_in[7:0]), .tx(uart_tx), .tx_busy
  );

  uart_rx receiver (
    .clk, .arst_n, .rx(uart_rx), .take, .rx_byte
  );

  // ------------------------------------------------------------------------
  // completion and read data
  // ------------------------------------------------------------------------
  assign take = io_read && (target == ramio_pkg::tgt_uart_in) &&
                (req.read_type != ramio_pkg::rd_none);
  assign done = cache_done || io_done || (tx_busy_q && !tx_busy);  // tx: stop bit sent
  assign data_out_ready = done && (req.read_type != ramio_pkg::rd_none);
  assign data_out = (target == ramio_pkg::tgt_ram) ? cache_word : io_word;

  assign br_cmd     = br_command.cmd;
  assign br_addr    = br_command.addr;
  assign br_wr_data = br_command.wr_data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      led       <= '0;
      io_done   <= 1'b0;
      tx_busy_q <= 1'b0;
    end else begin
      io_done   <= led_write || io_read;  // single cycle i/o
      tx_busy_q <= tx_busy;
      if (led_write) begin
        led <= req.data_in[3:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (io_read) begin
      case (target)
        ramio_pkg::tgt_uart_in: io_word <= rx_byte[8] ? {24'b0, rx_byte[7:0]} : 32'hFFFF_FFFF;
        ramio_pkg::tgt_led:     io_word <= {28'b0, led};
        default:                io_word <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ramio_settings.svh"

module uart_rx (
  input  wire        clk,
  input  wire        arst_n,
  input  wire        rx,
  input  wire        take,
  output logic [8:0] rx_byte
);

  localparam int unsigned CLKS_PER_BIT = `CLOCK_FREQUENCY_HZ / `UART_BAUD_RATE;

  logic        rx_meta;
  logic        rx_sync;
  logic        active;
  logic        valid;
  logic [3:0]  bit_cnt;  // 0 start, 1..8 data, 9 stop
  logic [15:0] baud_cnt;
  logic [7:0]  shift;
  logic [7:0]  data;
  logic        sample;

  assign rx_byte = {valid, data};
  assign sample  = active && (baud_cnt == '0);  // mid-bit

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      active   <= 1'b0;
      valid    <= 1'b0;
      bit_cnt  <= '0;
      baud_cnt <= '0;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      if (take) begin
        valid <= 1'b0;
      end
      if (!active) begin
        if (!rx_sync) begin  // falling edge of start bit
          active   <= 1'b1;
          bit_cnt  <= '0;
          baud_cnt <= 16'(CLKS_PER_BIT / 2 - 1);
        end
      end else if (!sample) begin
        baud_cnt <= baud_cnt - 16'd1;
      end else begin
        baud_cnt <= 16'(CLKS_PER_BIT - 1);
        bit_cnt  <= bit_cnt + 4'd1;
        if ((bit_cnt == 4'd0) && rx_sync) begin
          active <= 1'b0;  // glitch, not a start bit
        end else if (bit_cnt == 4'd9) begin
          active <= 1'b0;
          if (rx_sync) begin
            valid <= 1'b1;  // good stop bit
          end
        end
      end
    end
  end

  // data bits shift in lsb first
  always_ff @(posedge clk) begin
    if (sample) begin
      if ((bit_cnt >= 4'd1) && (bit_cnt <= 4'd8)) begin
        shift <= {rx_sync, shift[7:1]};
      end
      if ((bit_cnt == 4'd9) && rx_sync) begin
        data <= shift;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ramio_settings.svh"

module uart_tx (
  input  wire       clk,
  input  wire       arst_n,
  input  wire       start,
  input  wire [7:0] data,
  output logic      tx,
  output logic      tx_busy
);

  localparam int unsigned CLKS_PER_BIT = `CLOCK_FREQUENCY_HZ / `UART_BAUD_RATE;

  logic [9:0]  frame;  // stop, data lsb first, start
  logic [3:0]  bit_cnt;
  logic [15:0] baud_cnt;
  logic        bit_end;

  assign bit_end = (baud_cnt == 16'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx       <= 1'b1;  // line idles high
      tx_busy  <= 1'b0;
      bit_cnt  <= '0;
      baud_cnt <= '0;
    end else if (!tx_busy) begin
      if (start) begin
        tx_busy  <= 1'b1;
        tx       <= 1'b0;  // start bit
        bit_cnt  <= '0;
        baud_cnt <= '0;
      end
    end else if (!bit_end) begin
      baud_cnt <= baud_cnt + 16'd1;
    end else begin
      baud_cnt <= '0;
      if (bit_cnt == 4'd9) begin  // stop bit done
        tx_busy <= 1'b0;
        tx      <= 1'b1;
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
        tx      <= frame[1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!tx_busy && start) begin
      frame <= {1'b1, data, 1'b0};
    end else if (tx_busy && bit_end) begin
      frame <= {1'b1, frame[9:1]};
    end
  end

endmodule

`default_nettype wire

// ==== verif/ramio_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ramio_checker (
  input wire clk,
  input wire arst_n,
  input wire busy,
  input wire data_out_ready,
  input wire br_cmd,
  input wire br_cmd_en,
  input wire br_rd_data_valid,
  input wire uart_tx,
  input wire tx_busy
);

  logic rd_pending;  // one br read in flight

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_pending <= 1'b0;
    end else if (br_cmd_en && !br_cmd) begin
      rd_pending <= 1'b1;
    end else if (br_rd_data_valid) begin
      rd_pending <= 1'b0;
    end
  end

  // ------------------------------------------------------------------------
  // request port
  // ------------------------------------------------------------------------
  busy_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !busy)
    else $error("busy high right after reset");

  ready_only_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
    data_out_ready |-> busy)
    else $error("data_out_ready outside a busy period");

  // ------------------------------------------------------------------------
  // burst ram port and serial line
  // ------------------------------------------------------------------------
  cmd_en_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    br_cmd_en |=> !br_cmd_en)
    else $error("br_cmd_en held longer than one cycle");

  no_cmd_during_read: assert property (@(posedge clk) disable iff (!arst_n)
    br_cmd_en |-> !rd_pending)
    else $error("br_cmd_en while a br read is outstanding");

  tx_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
    !tx_busy |-> uart_tx)
    else $error("uart_tx low while the transmitter is idle");

endmodule

bind ramio_top ramio_checker checker0 (
  .clk, .arst_n, .busy, .data_out_ready, .br_cmd, .br_cmd_en, .br_rd_data_valid,
  .uart_tx, .tx_busy
);

`default_nettype wire

// ==== verif/tb_ramio.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ramio_settings.svh"

module tb_ramio;

  localparam int CLKS_PER_BIT = `CLOCK_FREQUENCY_HZ / `UART_BAUD_RATE;
  // one uart frame is ~2.6k cycles, ram traffic a few thousand more
  localparam int CYCLE_LIMIT  = 200_000;

  logic                             clk;
  logic                             arst_n;
  logic                             enable;
  ramio_pkg::write_type_e           write_type;
  ramio_pkg::read_type_e            read_type;
  logic [31:0]                      address;
  logic [31:0]                      data_in;
  logic [31:0]                      data_out;
  logic                             data_out_ready;
  logic                             busy;
  logic [3:0]                       led;
  wire                              serial_loop;  // tx looped back to rx
  logic                             br_cmd;
  logic                             br_cmd_en;
  logic [`RAM_ADDRESS_BITWIDTH-1:0] br_addr;
  logic [63:0]                      br_wr_data;
  logic [63:0]                      br_rd_data;
  logic                             br_rd_data_valid;

  logic [63:0] ram_mem [logic [`RAM_ADDRESS_BITWIDTH-1:0]];
  logic [7:0]  ref_mem [logic [31:0]];  // byte reference of ram space
  logic [`RAM_ADDRESS_BITWIDTH-1:0] rd_addr;
  int          rd_wait;
  int          cycle_count;
  bit          side_traffic;  // random enables while busy
  bit          run_ended;

  ramio_top dut0 (
    .clk, .arst_n, .enable, .write_type, .read_type, .address, .data_in,
    .data_out, .data_out_ready, .busy, .led, .uart_tx(serial_loop), .uart_rx(serial_loop),
    .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_rd_data, .br_rd_data_valid
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      run_ended = 1'b1;
      $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
  end

  final begin
    if (!run_ended) begin
      $display("*** TEST FAILED ***");
    end
  end

  // ------------------------------------------------------------------------
  // burst ram model
  // ------------------------------------------------------------------------
  function automatic logic [63:0] fill_word(input logic [`RAM_ADDRESS_BITWIDTH-1:0] a);
    return {a, 11'h5a3, a, 11'h2c7};  // never written words
  endfunction

  function automatic logic [63:0] ram_word(input logic [`RAM_ADDRESS_BITWIDTH-1:0] a);
    if (ram_mem.exists(a)) begin
      return ram_mem[a];
    end else begin
      return fill_word(a);
    end
  endfunction

  always @(negedge clk) begin
    br_rd_data_valid = 1'b0;
    if (rd_wait > 0) begin
      rd_wait--;
      if (rd_wait == 0) begin
        br_rd_data       = ram_word(rd_addr);
        br_rd_data_valid = 1'b1;
      end
    end
    if (arst_n && br_cmd_en) begin
      if (br_cmd) begin
        ram_mem[br_addr] = br_wr_data;  // full word, no mask
      end else begin
        rd_addr = br_addr;
        rd_wait = $urandom_range(8, 3);
      end
    end
  end

  // ------------------------------------------------------------------------
  // reference memory, little endian
  // ------------------------------------------------------------------------
  function automatic logic [7:0] ref_byte(input logic [31:0] a);
    logic [63:0] w;
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end else begin
      w = fill_word(a[23:3]);
      return w[{a[2:0], 3'b0} +: 8];
    end
  endfunction

  function automatic logic [63:0] ref_line(input logic [31:0] a);
    logic [63:0] l;
    for (int i = 0; i < 8; i++) begin
      l[8*i +: 8] = ref_byte(a + 32'(i));
    end
    return l;
  endfunction

  function automatic logic [31:0] ref_load(input ramio_pkg::read_type_e rt,
                                           input logic [31:0] a);
    logic [31:0] w;
    w = {ref_byte(a + 32'd3), ref_byte(a + 32'd2), ref_byte(a + 32'd1), ref_byte(a)};
    case (rt)
      ramio_pkg::rd_byte:   return {{24{w[7]}}, w[7:0]};
      ramio_pkg::rd_half:   return {{16{w[15]}}, w[15:0]};
      ramio_pkg::rd_byte_u: return {24'd0, w[7:0]};
      ramio_pkg::rd_half_u: return {16'd0, w[15:0]};
      default:              return w;
    endcase
  endfunction

  task automatic ref_store(input ramio_pkg::write_type_e wt, input logic [31:0] a,
                           input logic [31:0] d);
    int n;
    n = (wt == ramio_pkg::wr_byte) ? 1 : (wt == ramio_pkg::wr_half) ? 2 :
        (wt == ramio_pkg::wr_word) ? 4 : 0;
    for (int i = 0; i < n; i++) begin
      ref_mem[a + 32'(i)] = d[8*i +: 8];
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      run_ended = 1'b1;
      $display("Fail %s expected %h actual %h", name, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_true(input bit ok, input string what);
    assert (ok) else begin
      run_ended = 1'b1;
      $display("%s", what);
      $display("*** TEST FAILED ***");
      $fatal(1, "check failed");
    end
  endtask

  // ------------------------------------------------------------------------
  // request driver
  // ------------------------------------------------------------------------
  // four lines sharing index 0 plus one more, word aligned
  function automatic logic [31:0] pick_address();
    logic [31:0] base;
    if ($urandom_range(4, 0) == 4) begin
      base = 32'h0000_2000;
    end else begin
      base = 32'h0000_1000 + 32'h80 * $urandom_range(3, 0);
    end
    return base + 32'd4 * $urandom_range(7, 0);
  endfunction

  function automatic ramio_pkg::read_type_e pick_read_type();
    case ($urandom_range(4, 0))
      0:       return ramio_pkg::rd_byte;
      1:       return ramio_pkg::rd_half;
      2:       return ramio_pkg::rd_byte_u;
      3:       return ramio_pkg::rd_half_u;
      default: return ramio_pkg::rd_word;
    endcase
  endfunction

  task automatic drive_side_traffic();
    if (side_traffic && busy && ($urandom_range(1, 0) == 1)) begin
      enable     = 1'b1;  // must be ignored by the dut
      write_type = ramio_pkg::wr_word;
      read_type  = ramio_pkg::rd_none;
      address    = ($urandom_range(7, 0) == 0) ? `ADDR_LED : pick_address();
      data_in    = $urandom;
    end else begin
      enable = 1'b0;
    end
  endtask

  task automatic do_access(input ramio_pkg::write_type_e wt, input ramio_pkg::read_type_e rt,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output int done_at);
    int n;
    int pulses;
    int ready_at;
    n        = 0;
    pulses   = 0;
    ready_at = -1;
    rdata    = '0;
    @(negedge clk);
    enable     = 1'b1;
    write_type = wt;
    read_type  = rt;
    address    = addr;
    data_in    = wdata;
    @(posedge clk);  // busy is low, so this edge accepts
    @(negedge clk);
    check_true(busy == 1'b1, "request was not accepted");
    if (data_out_ready) begin
      pulses++;
      ready_at = 0;
      rdata    = data_out;
    end
    drive_side_traffic();
    while (busy) begin
      @(negedge clk);
      n++;
      if (data_out_ready) begin
        pulses++;
        ready_at = n;
        rdata    = data_out;
      end
      drive_side_traffic();
    end
    done_at = n;  // edge after acceptance on which busy fell
    check_value("data_out_ready count", (rt != ramio_pkg::rd_none) ? 64'd1 : 64'd0,
                64'(pulses));
    if (rt != ramio_pkg::rd_none) begin
      // pulse sits in the last busy cycle
      check_value("data_out_ready cycle", 64'(done_at - 1), 64'(ready_at));
    end
    if (addr[31:24] == 8'h00) begin
      ref_store(wt, addr, wdata);
    end
  endtask

  task automatic store(input ramio_pkg::write_type_e wt, input logic [31:0] addr,
                       input logic [31:0] d);
    logic [31:0] ignored;
    int          done_at;
    do_access(wt, ramio_pkg::rd_none, addr, d, ignored, done_at);
  endtask

  task automatic read_check(input ramio_pkg::read_type_e rt, input logic [31:0] addr);
    logic [31:0] got;
    int          done_at;
    do_access(ramio_pkg::wr_none, rt, addr, 32'd0, got, done_at);
    check_value("data_out", 64'(ref_load(rt, addr)), 64'(got));
  endtask

  // ------------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------------
  initial begin
    logic [31:0] got;
    logic [31:0] wdata;
    logic [3:0]  led_before;
    int          done_at;
    void'($urandom(32'h223ebca6));
    clk              = 1'b0;
    arst_n           = 1'b0;
    enable           = 1'b0;
    write_type       = ramio_pkg::wr_none;
    read_type        = ramio_pkg::rd_none;
    address          = '0;
    data_in          = '0;
    br_rd_data       = '0;
    br_rd_data_valid = 1'b0;
    rd_wait          = 0;
    cycle_count      = 0;
    side_traffic     = 1'b0;
    run_ended        = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // word stores miss, loads hit
    for (int i = 0; i < 8; i++) begin
      store(ramio_pkg::wr_word, 32'h1000 + 32'(4 * i), $urandom);
    end
    for (int i = 0; i < 8; i++) begin
      do_access(ramio_pkg::wr_none, ramio_pkg::rd_word, 32'h1000 + 32'(4 * i), 32'd0,
                got, done_at);
      check_value("data_out", 64'(ref_load(ramio_pkg::rd_word, 32'h1000 + 32'(4 * i))),
                  64'(got));
      check_value("hit done cycle", 64'd2, 64'(done_at));
    end

    // sized stores, every load type
    for (int i = 0; i < 8; i++) begin
      store(ramio_pkg::wr_byte, 32'h2000 + 32'(i), $urandom);
    end
    for (int i = 0; i < 4; i++) begin
      store(ramio_pkg::wr_half, 32'h2008 + 32'(2 * i), $urandom);
    end
    for (int i = 0; i < 16; i++) begin
      read_check(ramio_pkg::rd_byte, 32'h2000 + 32'(i));
      read_check(ramio_pkg::rd_byte_u, 32'h2000 + 32'(i));
      if (i % 2 == 0) begin
        read_check(ramio_pkg::rd_half, 32'h2000 + 32'(i));
        read_check(ramio_pkg::rd_half_u, 32'h2000 + 32'(i));
      end
      if (i % 4 == 0) begin
        read_check(ramio_pkg::rd_word, 32'h2000 + 32'(i));
      end
    end

    // index 0 conflicts, dirty lines go back to ram
    for (int k = 1; k < 4; k++) begin
      store(ramio_pkg::wr_word, 32'h1000 + 32'(32'h80 * k), $urandom);
    end
    check_value("ram_mem", ref_line(32'h1000), ram_word(21'(32'h1000 >> 3)));
    check_value("ram_mem", ref_line(32'h2000), ram_word(21'(32'h2000 >> 3)));
    read_check(ramio_pkg::rd_word, 32'h1000);
    read_check(ramio_pkg::rd_word, 32'h1004);
    read_check(ramio_pkg::rd_word, 32'h2004);
    read_check(ramio_pkg::rd_word, 32'h1080);

    // led register
    wdata = $urandom;
    do_access(ramio_pkg::wr_word, ramio_pkg::rd_none, `ADDR_LED, wdata, got, done_at);
    check_value("led", 64'(wdata[3:0]), 64'(led));
    check_value("led done cycle", 64'd2, 64'(done_at));

    // uart loopback
    wdata = $urandom;
    do_access(ramio_pkg::wr_word, ramio_pkg::rd_none, `ADDR_UART_OUT, wdata, got, done_at);
    check_true(done_at >= 10 * CLKS_PER_BIT, "busy fell before the uart stop bit was sent");
    do_access(ramio_pkg::wr_none, ramio_pkg::rd_word, `ADDR_UART_IN, 32'd0, got, done_at);
    check_value("data_out", 64'({24'd0, wdata[7:0]}), 64'(got));
    check_value("uart_in done cycle", 64'd2, 64'(done_at));
    do_access(ramio_pkg::wr_none, ramio_pkg::rd_word, `ADDR_UART_IN, 32'd0, got, done_at);
    check_value("data_out", 64'(32'hFFFF_FFFF), 64'(got));

    // random traffic with enables during busy
    led_before   = led;
    side_traffic = 1'b1;
    repeat (60) begin
      if ($urandom_range(1, 0) == 1) begin
        store(ramio_pkg::wr_word, pick_address(), $urandom);
      end else begin
        read_check(pick_read_type(), pick_address());
      end
    end
    side_traffic = 1'b0;
    check_value("led", 64'(led_before), 64'(led));

    run_ended = 1'b1;
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
